// ==== Bender.yml ====
package:
  name: looper_backend

sources:
  - hw/looper_pkg.sv
  - hw/phys_reg_file.sv
  - hw/alu_lane.sv
  - hw/mult_lane.sv
  - hw/looper_backend.sv
  - target: test
    files:
      - testbench/tb_looper_backend.sv

// ==== filelist.f ====
hw/looper_pkg.sv
hw/phys_reg_file.sv
hw/alu_lane.sv
hw/mult_lane.sv
hw/looper_backend.sv
testbench/tb_looper_backend.sv

// ==== hw/alu_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_lane (
	input  logic clk,
	input  logic rst,

	input  logic vld,
	input  looper_pkg::alu_mode_t mode,
	input  looper_pkg::preg_t src1, src2,
	input  looper_pkg::word_t imm,
	input  logic imm_vld,
	input  looper_pkg::preg_t dst,
	input  logic reg_wrt,
	input  looper_pkg::rob_idx_t idx,

	output looper_pkg::preg_t rd1, rd2,
	input  looper_pkg::word_t rd1_data, rd2_data,

	output logic done_vld,
	output looper_pkg::rob_idx_t done_idx,
	output logic wrt_vld,
	output looper_pkg::preg_t wrt_pnum,
	output looper_pkg::word_t wrt_data
);

	import looper_pkg::*;

	// issue stage
	logic is_vld, is_imm_vld, is_reg_wrt;
	alu_mode_t is_mode;
	preg_t is_src1, is_src2, is_dst;
	word_t is_imm;
	rob_idx_t is_idx;

	// register read stage
	logic rr_vld, rr_imm_vld, rr_reg_wrt;
	alu_mode_t rr_mode;
	preg_t rr_src1, rr_src2, rr_dst;
	word_t rr_imm;
	rob_idx_t rr_idx;

	// execute stage
	logic ex_vld, ex_imm_vld, ex_reg_wrt;
	alu_mode_t ex_mode;
	word_t ex_op1, ex_rt, ex_imm, ex_op2, ex_result;
	preg_t ex_dst;
	rob_idx_t ex_idx;
	logic [SHAMT_W-1:0] ex_shamt;

	// writeback stage
	logic wb_vld, wb_reg_wrt;
	preg_t wb_dst;
	rob_idx_t wb_idx;
	word_t wb_data;

	always_ff @(posedge clk) begin
		if (rst) begin
			is_vld <= 1'b0;
			rr_vld <= 1'b0;
			ex_vld <= 1'b0;
			wb_vld <= 1'b0;
		end else begin
			is_vld <= vld;
			rr_vld <= is_vld;
			ex_vld <= rr_vld;
			wb_vld <= ex_vld;
		end
	end

	always_ff @(posedge clk) begin
		{is_mode, is_src1, is_src2, is_imm} <= {mode, src1, src2, imm};
		{is_imm_vld, is_dst, is_reg_wrt, is_idx} <= {imm_vld, dst, reg_wrt, idx};
		{rr_mode, rr_src1, rr_src2, rr_imm} <= {is_mode, is_src1, is_src2, is_imm};
		{rr_imm_vld, rr_dst, rr_reg_wrt, rr_idx} <= {is_imm_vld, is_dst, is_reg_wrt, is_idx};
		// operands captured from the register file read
		ex_op1 <= rd1_data;
		ex_rt <= rd2_data;
		{ex_mode, ex_imm, ex_imm_vld} <= {rr_mode, rr_imm, rr_imm_vld};
		{ex_dst, ex_reg_wrt, ex_idx} <= {rr_dst, rr_reg_wrt, rr_idx};
		{wb_dst, wb_reg_wrt, wb_idx} <= {ex_dst, ex_reg_wrt, ex_idx};
		wb_data <= ex_result;
	end

	assign rd1 = rr_src1;
	assign rd2 = rr_src2;

	assign ex_op2 = ex_imm_vld ? ex_imm : ex_rt;
	assign ex_shamt = ex_op2[SHAMT_W-1:0];

	always_comb begin
		case (ex_mode)
			ALU_ADD: ex_result = ex_op1 + ex_op2;
			ALU_SUB: ex_result = ex_op1 - ex_op2;
			ALU_AND: ex_result = ex_op1 & ex_op2;
			ALU_OR:  ex_result = ex_op1 | ex_op2;
			ALU_XOR: ex_result = ex_op1 ^ ex_op2;
			ALU_SLL: ex_result = ex_op1 << ex_shamt;
			ALU_SRL: ex_result = ex_op1 >> ex_shamt;
			ALU_LDI: ex_result = ex_imm;
			default: ex_result = '0;
		endcase
	end

	assign done_vld = wb_vld;
	assign done_idx = wb_idx;
	assign wrt_vld = wb_vld & wb_reg_wrt;
	assign wrt_pnum = wb_dst;
	assign wrt_data = wb_data;

endmodule

`default_nettype wire

// ==== hw/looper_backend.sv ====
`timescale 1ns/1ps
`default_nettype none

module looper_backend #(
	parameter int NUM_PREGS = 64
) (
	input  logic clk,
	input  logic rst,

	// alu lane 1
	input  logic alu1_vld,
	input  looper_pkg::alu_mode_t alu1_mode,
	input  looper_pkg::preg_t alu1_src1, alu1_src2, alu1_dst,
	input  looper_pkg::word_t alu1_imm,
	input  logic alu1_imm_vld, alu1_reg_wrt,
	input  looper_pkg::rob_idx_t alu1_idx,
	output logic alu1_done_vld,
	output looper_pkg::rob_idx_t alu1_done_idx,
	output logic alu1_wrt_vld,
	output looper_pkg::preg_t alu1_wrt_pnum,
	output looper_pkg::word_t alu1_wrt_data,

	// alu lane 2
	input  logic alu2_vld,
	input  looper_pkg::alu_mode_t alu2_mode,
	input  looper_pkg::preg_t alu2_src1, alu2_src2, alu2_dst,
	input  looper_pkg::word_t alu2_imm,
	input  logic alu2_imm_vld, alu2_reg_wrt,
	input  looper_pkg::rob_idx_t alu2_idx,
	output logic alu2_done_vld,
	output looper_pkg::rob_idx_t alu2_done_idx,
	output logic alu2_wrt_vld,
	output looper_pkg::preg_t alu2_wrt_pnum,
	output looper_pkg::word_t alu2_wrt_data,

	// multiplier lane
	input  logic mult_vld,
	input  looper_pkg::preg_t mult_src1, mult_src2, mult_dst,
	input  logic mult_reg_wrt,
	input  looper_pkg::rob_idx_t mult_idx,
	output logic mult_done_vld,
	output looper_pkg::rob_idx_t mult_done_idx,
	output logic mult_wrt_vld,
	output looper_pkg::preg_t mult_wrt_pnum,
	output looper_pkg::word_t mult_wrt_data
);

	import looper_pkg::*;

	// register file read ports
	preg_t alu1_rd1, alu1_rd2, alu2_rd1, alu2_rd2, mult_rd1, mult_rd2;
	word_t alu1_rd1_data, alu1_rd2_data, alu2_rd1_data, alu2_rd2_data;
	word_t mult_rd1_data, mult_rd2_data;

	phys_reg_file #(
		.NUM_PREGS(NUM_PREGS)
	) u_prf (
		.clk(clk), .rst(rst),
		.alu1_rd1(alu1_rd1), .alu1_rd2(alu1_rd2),
		.alu2_rd1(alu2_rd1), .alu2_rd2(alu2_rd2),
		.mult_rd1(mult_rd1), .mult_rd2(mult_rd2),
		.alu1_rd1_data(alu1_rd1_data), .alu1_rd2_data(alu1_rd2_data),
		.alu2_rd1_data(alu2_rd1_data), .alu2_rd2_data(alu2_rd2_data),
		.mult_rd1_data(mult_rd1_data), .mult_rd2_data(mult_rd2_data),
		// writeback buses double as write ports
		.alu1_wr_vld(alu1_wrt_vld), .alu1_wr_pnum(alu1_wrt_pnum),
		.alu1_wr_data(alu1_wrt_data),
		.alu2_wr_vld(alu2_wrt_vld), .alu2_wr_pnum(alu2_wrt_pnum),
		.alu2_wr_data(alu2_wrt_data),
		.mult_wr_vld(mult_wrt_vld), .mult_wr_pnum(mult_wrt_pnum),
		.mult_wr_data(mult_wrt_data)
	);

	alu_lane u_alu1 (
		.clk(clk), .rst(rst),
		.vld(alu1_vld), .mode(alu1_mode),
		.src1(alu1_src1), .src2(alu1_src2),
		.imm(alu1_imm), .imm_vld(alu1_imm_vld),
		.dst(alu1_dst), .reg_wrt(alu1_reg_wrt), .idx(alu1_idx),
		.rd1(alu1_rd1), .rd2(alu1_rd2),
		.rd1_data(alu1_rd1_data), .rd2_data(alu1_rd2_data),
		.done_vld(alu1_done_vld), .done_idx(alu1_done_idx),
		.wrt_vld(alu1_wrt_vld), .wrt_pnum(alu1_wrt_pnum), .wrt_data(alu1_wrt_data)
	);

	alu_lane u_alu2 (
		.clk(clk), .rst(rst),
		.vld(alu2_vld), .mode(alu2_mode),
		.src1(alu2_src1), .src2(alu2_src2),
		.imm(alu2_imm), .imm_vld(alu2_imm_vld),
		.dst(alu2_dst), .reg_wrt(alu2_reg_wrt), .idx(alu2_idx),
		.rd1(alu2_rd1), .rd2(alu2_rd2),
		.rd1_data(alu2_rd1_data), .rd2_data(alu2_rd2_data),
		.done_vld(alu2_done_vld), .done_idx(alu2_done_idx),
		.wrt_vld(alu2_wrt_vld), .wrt_pnum(alu2_wrt_pnum), .wrt_data(alu2_wrt_data)
	);

	mult_lane u_mult (
		.clk(clk), .rst(rst),
		.vld(mult_vld),
		.src1(mult_src1), .src2(mult_src2),
		.dst(mult_dst), .reg_wrt(mult_reg_wrt), .idx(mult_idx),
		.rd1(mult_rd1), .rd2(mult_rd2),
		.rd1_data(mult_rd1_data), .rd2_data(mult_rd2_data),
		.done_vld(mult_done_vld), .done_idx(mult_done_idx),
		.wrt_vld(mult_wrt_vld), .wrt_pnum(mult_wrt_pnum), .wrt_data(mult_wrt_data)
	);

endmodule

`default_nettype wire

// ==== hw/looper_pkg.sv ====
`default_nettype none

package looper_pkg;

	localparam int WORD_W = 16;
	localparam int PREG_W = 6;
	localparam int ROB_IDX_W = 6;

	// shift amount is the low bits of operand 2
	localparam int SHAMT_W = 4;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [PREG_W-1:0] preg_t;
	typedef logic [ROB_IDX_W-1:0] rob_idx_t;

	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_XOR = 3'd4,
		ALU_SLL = 3'd5,
		ALU_SRL = 3'd6,
		// result is the immediate, registers ignored
		ALU_LDI = 3'd7
	} alu_mode_t;

endpackage

`default_nettype wire

// ==== hw/mult_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

module mult_lane (
	input  logic clk,
	input  logic rst,

	input  logic vld,
	input  looper_pkg::preg_t src1, src2, dst,
	input  logic reg_wrt,
	input  looper_pkg::rob_idx_t idx,

	output looper_pkg::preg_t rd1, rd2,
	input  looper_pkg::word_t rd1_data, rd2_data,

	output logic done_vld,
	output looper_pkg::rob_idx_t done_idx,
	output logic wrt_vld,
	output looper_pkg::preg_t wrt_pnum,
	output looper_pkg::word_t wrt_data
);

	import looper_pkg::*;

	localparam int HALF_W = WORD_W / 2;

	logic is_vld, rr_vld, ex_vld, mp_vld, wb_vld;
	preg_t is_src1, is_src2, is_dst, rr_src1, rr_src2, rr_dst;
	preg_t ex_dst, mp_dst, wb_dst;
	logic is_reg_wrt, rr_reg_wrt, ex_reg_wrt, mp_reg_wrt, wb_reg_wrt;
	rob_idx_t is_idx, rr_idx, ex_idx, mp_idx, wb_idx;
	word_t ex_op1, ex_op2, wb_data;

	// partial products, low half of op2 and high half of op2
	word_t mp_lo;
	logic [HALF_W-1:0] mp_hi;

	always_ff @(posedge clk) begin
		if (rst) begin
			is_vld <= 1'b0;
			rr_vld <= 1'b0;
			ex_vld <= 1'b0;
			mp_vld <= 1'b0;
			wb_vld <= 1'b0;
		end else begin
			is_vld <= vld;
			rr_vld <= is_vld;
			ex_vld <= rr_vld;
			mp_vld <= ex_vld;
			wb_vld <= mp_vld;
		end
	end

	always_ff @(posedge clk) begin
		{is_src1, is_src2, is_dst, is_reg_wrt, is_idx} <= {src1, src2, dst, reg_wrt, idx};
		{rr_src1, rr_src2} <= {is_src1, is_src2};
		{rr_dst, rr_reg_wrt, rr_idx} <= {is_dst, is_reg_wrt, is_idx};
		ex_op1 <= rd1_data;
		ex_op2 <= rd2_data;
		{ex_dst, ex_reg_wrt, ex_idx} <= {rr_dst, rr_reg_wrt, rr_idx};
		// only the low product bits survive, so the high half needs 8 bits
		mp_lo <= ex_op1 * ex_op2[HALF_W-1:0];
		mp_hi <= ex_op1[HALF_W-1:0] * ex_op2[WORD_W-1:HALF_W];
		{mp_dst, mp_reg_wrt, mp_idx} <= {ex_dst, ex_reg_wrt, ex_idx};
		wb_data <= mp_lo + {mp_hi, {HALF_W{1'b0}}};
		{wb_dst, wb_reg_wrt, wb_idx} <= {mp_dst, mp_reg_wrt, mp_idx};
	end

	assign rd1 = rr_src1;
	assign rd2 = rr_src2;

	assign done_vld = wb_vld;
	assign done_idx = wb_idx;
	assign wrt_vld = wb_vld & wb_reg_wrt;
	assign wrt_pnum = wb_dst;
	assign wrt_data = wb_data;

endmodule

`default_nettype wire

// ==== hw/phys_reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module phys_reg_file #(
	parameter int NUM_PREGS = 64
) (
	input  logic clk,
	input  logic rst,

	// read ports, one pair per lane
	input  looper_pkg::preg_t alu1_rd1, alu1_rd2,
	input  looper_pkg::preg_t alu2_rd1, alu2_rd2,
	input  looper_pkg::preg_t mult_rd1, mult_rd2,
	output looper_pkg::word_t alu1_rd1_data, alu1_rd2_data,
	output looper_pkg::word_t alu2_rd1_data, alu2_rd2_data,
	output looper_pkg::word_t mult_rd1_data, mult_rd2_data,

	// write ports from the lane writeback buses
	input  logic alu1_wr_vld,
	input  looper_pkg::preg_t alu1_wr_pnum,
	input  looper_pkg::word_t alu1_wr_data,
	input  logic alu2_wr_vld,
	input  looper_pkg::preg_t alu2_wr_pnum,
	input  looper_pkg::word_t alu2_wr_data,
	input  logic mult_wr_vld,
	input  looper_pkg::preg_t mult_wr_pnum,
	input  looper_pkg::word_t mult_wr_data
);

	import looper_pkg::*;

	word_t regs [NUM_PREGS];

	// write-first read, checked in rising priority so the winner is last
	function automatic word_t read_port(input preg_t pnum);
		word_t data;
		data = regs[pnum];
		if (alu1_wr_vld && alu1_wr_pnum == pnum)
			data = alu1_wr_data;
		if (alu2_wr_vld && alu2_wr_pnum == pnum)
			data = alu2_wr_data;
		if (mult_wr_vld && mult_wr_pnum == pnum)
			data = mult_wr_data;
		return data;
	endfunction

	always_comb begin
		alu1_rd1_data = read_port(alu1_rd1);
		alu1_rd2_data = read_port(alu1_rd2);
		alu2_rd1_data = read_port(alu2_rd1);
		alu2_rd2_data = read_port(alu2_rd2);
		mult_rd1_data = read_port(mult_rd1);
		mult_rd2_data = read_port(mult_rd2);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_PREGS; i++)
				regs[i] <= '0;
		end else begin
			// same register from several lanes: mult over alu2 over alu1
			if (alu1_wr_vld)
				regs[alu1_wr_pnum] <= alu1_wr_data;
			if (alu2_wr_vld)
				regs[alu2_wr_pnum] <= alu2_wr_data;
			if (mult_wr_vld)
				regs[mult_wr_pnum] <= mult_wr_data;
		end
	end

endmodule

`default_nettype wire

// ==== testbench/tb_looper_backend.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_looper_backend;

	import looper_pkg::*;

	localparam int N_LDI = 32;
	localparam int N_MIX = 128;
	localparam int N_MUL = 64;
	localparam int N_PRIO = 8;
	localparam int N_NOWR = 32;
	// issued items over all lanes and tests
	localparam int TOTAL_ITEMS = 8 + 2 * N_LDI + 2 * N_MIX + N_MUL + 4 * N_PRIO + 4 * N_NOWR;

	typedef struct packed {
		logic v;
		alu_mode_t mode;
		preg_t s1, s2, dst;
		word_t imm;
		logic iv, rw;
		rob_idx_t idx;
		word_t a, b, res;
	} item_t;

	logic clk = 1'b0;
	logic rst;
	logic alu1_vld, alu1_imm_vld, alu1_reg_wrt, alu2_vld, alu2_imm_vld, alu2_reg_wrt;
	alu_mode_t alu1_mode, alu2_mode;
	preg_t alu1_src1, alu1_src2, alu1_dst, alu2_src1, alu2_src2, alu2_dst;
	word_t alu1_imm, alu2_imm;
	rob_idx_t alu1_idx, alu2_idx, mult_idx, next_idx;
	logic mult_vld, mult_reg_wrt;
	preg_t mult_src1, mult_src2, mult_dst;
	logic [2:0] done_vld, wrt_vld;
	rob_idx_t [2:0] done_idx;
	preg_t [2:0] wrt_pnum;
	word_t [2:0] wrt_data;

	// model pipelines per lane (alu1 alu2 mult)
	item_t st_is [3], st_rr [3], st_ex [3], st_mp [3], st_wb [3];
	word_t model_regs [64];
	string lane_name [3] = '{"alu1", "alu2", "mult"};
	string cur_test;
	int errors, test_errs, tests_run, tests_failed;
	preg_t ldi_dst [N_LDI];
	preg_t prio_reg;

	looper_backend #(.NUM_PREGS(64)) i_dut (
		.clk(clk), .rst(rst),
		.alu1_vld(alu1_vld), .alu1_mode(alu1_mode), .alu1_src1(alu1_src1),
		.alu1_src2(alu1_src2), .alu1_dst(alu1_dst), .alu1_imm(alu1_imm),
		.alu1_imm_vld(alu1_imm_vld), .alu1_reg_wrt(alu1_reg_wrt), .alu1_idx(alu1_idx),
		.alu1_done_vld(done_vld[0]), .alu1_done_idx(done_idx[0]), .alu1_wrt_vld(wrt_vld[0]),
		.alu1_wrt_pnum(wrt_pnum[0]), .alu1_wrt_data(wrt_data[0]),
		.alu2_vld(alu2_vld), .alu2_mode(alu2_mode), .alu2_src1(alu2_src1),
		.alu2_src2(alu2_src2), .alu2_dst(alu2_dst), .alu2_imm(alu2_imm),
		.alu2_imm_vld(alu2_imm_vld), .alu2_reg_wrt(alu2_reg_wrt), .alu2_idx(alu2_idx),
		.alu2_done_vld(done_vld[1]), .alu2_done_idx(done_idx[1]), .alu2_wrt_vld(wrt_vld[1]),
		.alu2_wrt_pnum(wrt_pnum[1]), .alu2_wrt_data(wrt_data[1]),
		.mult_vld(mult_vld), .mult_src1(mult_src1), .mult_src2(mult_src2),
		.mult_dst(mult_dst), .mult_reg_wrt(mult_reg_wrt), .mult_idx(mult_idx),
		.mult_done_vld(done_vld[2]), .mult_done_idx(done_idx[2]), .mult_wrt_vld(wrt_vld[2]),
		.mult_wrt_pnum(wrt_pnum[2]), .mult_wrt_data(wrt_data[2])
	);

	initial begin
		forever #4 clk = ~clk;
	end

	task automatic check_value(string what, logic [31:0] exp, logic [31:0] act);
		if (exp !== act) begin
			$display("FAIL %s %s: expected %0h, got %0h at %0t", cur_test, what, exp, act,
				$time);
			errors++;
			test_errs++;
		end
	endtask

	function automatic word_t alu_result(alu_mode_t mode, word_t a, word_t b, word_t imm);
		case (mode)
			ALU_ADD: return a + b;
			ALU_SUB: return a - b;
			ALU_AND: return a & b;
			ALU_OR:  return a | b;
			ALU_XOR: return a ^ b;
			ALU_SLL: return a << b[SHAMT_W-1:0];
			ALU_SRL: return a >> b[SHAMT_W-1:0];
			default: return imm;
		endcase
	endfunction

	// write-first read where later lanes win
	function automatic word_t model_read(preg_t pnum);
		word_t data;
		data = model_regs[pnum];
		for (int l = 0; l < 3; l++)
			if (st_wb[l].v && st_wb[l].rw && st_wb[l].dst == pnum)
				data = st_wb[l].res;
		return data;
	endfunction

	function automatic item_t make_item(logic v, alu_mode_t mode, preg_t s1, preg_t s2,
			word_t imm, logic iv, preg_t dst, logic rw, rob_idx_t idx);
		item_t it;
		it = '0;
		it.v = v;
		it.mode = mode;
		it.s1 = s1;
		it.s2 = s2;
		it.imm = imm;
		it.iv = iv;
		it.dst = dst;
		it.rw = rw;
		it.idx = idx;
		return it;
	endfunction

	// one model cycle at the falling edge
	task automatic model_tick();
		item_t ex_new [3];
		if (rst) begin
			for (int l = 0; l < 3; l++) begin
				st_is[l] = '0;
				st_rr[l] = '0;
				st_ex[l] = '0;
				st_mp[l] = '0;
				st_wb[l] = '0;
			end
			for (int r = 0; r < 64; r++)
				model_regs[r] = '0;
		end else begin
			for (int l = 0; l < 3; l++) begin
				check_value({lane_name[l], " done_vld"}, st_wb[l].v, done_vld[l]);
				check_value({lane_name[l], " wrt_vld"}, st_wb[l].v & st_wb[l].rw, wrt_vld[l]);
				if (st_wb[l].v)
					check_value({lane_name[l], " done_idx"}, st_wb[l].idx, done_idx[l]);
				if (st_wb[l].v && st_wb[l].rw) begin
					check_value({lane_name[l], " wrt_pnum"}, st_wb[l].dst, wrt_pnum[l]);
					check_value({lane_name[l], " wrt_data"}, st_wb[l].res, wrt_data[l]);
				end
				ex_new[l] = st_rr[l];
				ex_new[l].a = model_read(st_rr[l].s1);
				ex_new[l].b = (l < 2 && st_rr[l].iv) ? st_rr[l].imm : model_read(st_rr[l].s2);
			end
			for (int l = 0; l < 3; l++)
				if (st_wb[l].v && st_wb[l].rw)
					model_regs[st_wb[l].dst] = st_wb[l].res;
			st_wb[2] = st_mp[2];
			st_mp[2] = st_ex[2];
			st_mp[2].res = st_ex[2].a * st_ex[2].b;
			for (int l = 0; l < 2; l++) begin
				st_wb[l] = st_ex[l];
				st_wb[l].res = alu_result(st_ex[l].mode, st_ex[l].a, st_ex[l].b, st_ex[l].imm);
			end
			for (int l = 0; l < 3; l++) begin
				st_ex[l] = ex_new[l];
				st_rr[l] = st_is[l];
			end
			st_is[0] = make_item(alu1_vld, alu1_mode, alu1_src1, alu1_src2, alu1_imm,
				alu1_imm_vld, alu1_dst, alu1_reg_wrt, alu1_idx);
			st_is[1] = make_item(alu2_vld, alu2_mode, alu2_src1, alu2_src2, alu2_imm,
				alu2_imm_vld, alu2_dst, alu2_reg_wrt, alu2_idx);
			st_is[2] = make_item(mult_vld, ALU_ADD, mult_src1, mult_src2, '0, 1'b0,
				mult_dst, mult_reg_wrt, mult_idx);
		end
	endtask

	always @(negedge clk)
		model_tick();

	task automatic clear_inputs();
		{alu1_vld, alu1_imm_vld, alu1_reg_wrt, alu2_vld, alu2_imm_vld, alu2_reg_wrt} <= '0;
		{alu1_src1, alu1_src2, alu1_dst, alu2_src1, alu2_src2, alu2_dst} <= '0;
		{alu1_imm, alu2_imm, alu1_idx, alu2_idx} <= '0;
		alu1_mode <= ALU_ADD;
		alu2_mode <= ALU_ADD;
		{mult_vld, mult_reg_wrt, mult_src1, mult_src2, mult_dst, mult_idx} <= '0;
	endtask

	task automatic next_cycle();
		@(posedge clk);
		clear_inputs();
	endtask

	function automatic preg_t rand_reg(int n);
		return preg_t'($urandom_range(0, n - 1));
	endfunction

	task automatic drive_alu(int lane, alu_mode_t mode, preg_t s1, preg_t s2, word_t imm,
			logic iv, preg_t dst, logic rw);
		if (lane == 0) begin
			{alu1_vld, alu1_mode, alu1_src1, alu1_src2} <= {1'b1, mode, s1, s2};
			{alu1_imm, alu1_imm_vld, alu1_dst, alu1_reg_wrt} <= {imm, iv, dst, rw};
			alu1_idx <= next_idx;
		end else begin
			{alu2_vld, alu2_mode, alu2_src1, alu2_src2} <= {1'b1, mode, s1, s2};
			{alu2_imm, alu2_imm_vld, alu2_dst, alu2_reg_wrt} <= {imm, iv, dst, rw};
			alu2_idx <= next_idx;
		end
		next_idx = next_idx + 1'b1;
	endtask

	task automatic drive_mult(preg_t s1, preg_t s2, preg_t dst, logic rw);
		{mult_vld, mult_src1, mult_src2, mult_dst, mult_reg_wrt} <= {1'b1, s1, s2, dst, rw};
		mult_idx <= next_idx;
		next_idx = next_idx + 1'b1;
	endtask

	task automatic rand_alu(int lane, int pool, logic rw);
		drive_alu(lane, alu_mode_t'($urandom_range(0, 7)), rand_reg(pool), rand_reg(pool),
			word_t'($urandom), $urandom_range(0, 1), rand_reg(pool), rw);
	endtask

	task automatic start_test(string name);
		cur_test = name;
		test_errs = 0;
	endtask

	// let the pipelines drain before reporting
	task automatic end_test();
		repeat (8) next_cycle();
		tests_run++;
		if (test_errs != 0)
			tests_failed++;
		$display("test %-10s %s (%0d errors)", cur_test, test_errs == 0 ? "passed" : "FAILED",
			test_errs);
	endtask

	initial begin
		void'($urandom(2191));
		rst = 1'b1;
		next_idx = '0;
		clear_inputs();
		repeat (4) @(posedge clk);
		rst <= 1'b0;

		start_test("reset");
		repeat (8) next_cycle();
		for (int i = 0; i < 8; i++) begin
			next_cycle();
			drive_alu(i % 2, ALU_ADD, rand_reg(64), rand_reg(64), '0, 1'b0, rand_reg(64), 1'b1);
		end
		end_test();

		start_test("ldi");
		for (int i = 0; i < N_LDI; i++) begin
			next_cycle();
			ldi_dst[i] = rand_reg(64);
			drive_alu(i % 2, ALU_LDI, rand_reg(64), rand_reg(64), word_t'($urandom),
				$urandom_range(0, 1), ldi_dst[i], 1'b1);
		end
		for (int i = 0; i < N_LDI; i++) begin
			next_cycle();
			drive_alu(i % 2, ALU_ADD, ldi_dst[i], '0, '0, 1'b1, ldi_dst[i], 1'b1);
		end
		end_test();

		// small register pool so that producers and consumers collide
		start_test("mixed");
		for (int i = 0; i < N_MIX; i++) begin
			next_cycle();
			rand_alu(0, 8, 1'b1);
			rand_alu(1, 8, 1'b1);
		end
		end_test();

		start_test("multiply");
		for (int i = 0; i < N_MUL; i++) begin
			next_cycle();
			drive_mult(rand_reg(16), rand_reg(16), rand_reg(16), 1'b1);
		end
		end_test();

		// mult issued one cycle early so all three write together
		start_test("priority");
		for (int g = 0; g < N_PRIO; g++) begin
			prio_reg = rand_reg(64);
			next_cycle();
			drive_mult(rand_reg(64), rand_reg(64), prio_reg, $urandom_range(0, 1));
			next_cycle();
			drive_alu(0, ALU_LDI, '0, '0, word_t'($urandom), 1'b0, prio_reg, 1'b1);
			drive_alu(1, ALU_LDI, '0, '0, word_t'($urandom), 1'b0, prio_reg,
				$urandom_range(0, 1));
			repeat (4) next_cycle();
			drive_alu(0, ALU_ADD, prio_reg, '0, '0, 1'b1, prio_reg, 1'b1);
		end
		end_test();

		start_test("no_write");
		for (int i = 0; i < N_NOWR; i++) begin
			next_cycle();
			rand_alu(0, 64, 1'b0);
			rand_alu(1, 64, 1'b0);
			drive_mult(rand_reg(64), rand_reg(64), rand_reg(64), 1'b0);
		end
		for (int i = 0; i < N_NOWR; i++) begin
			next_cycle();
			drive_alu(i % 2, ALU_OR, preg_t'(i), '0, '0, 1'b1, preg_t'(i), 1'b1);
		end
		end_test();

		$display("tests run %0d, tests failed %0d, check errors %0d", tests_run, tests_failed,
			errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	initial begin
		#(TOTAL_ITEMS * 8 * 2 + 200);
		$display("timeout: the run did not finish in %0d ns", TOTAL_ITEMS * 8 * 2 + 200);
		$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire
